/* files.f */
hw/stream_pkg.sv
hw/media_pkg.sv
hw/media_splitter.sv
hw/pixel_writer.sv
hw/frame_buffer.sv
hw/audio_fifo.sv
hw/media_rx_top.sv
verif/media_rx_tb.sv

/* hw/audio_fifo.sv */
`default_nettype none

module audio_fifo
    import media_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  media_byte_t push,
    input  logic        pop,
    output logic [7:0]  data,
    output logic        empty,
    output logic        overflow
);

    logic [7:0]                     mem [AUDIO_DEPTH];
    logic [$clog2(AUDIO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(AUDIO_DEPTH)-1:0] rd_ptr;
    audio_count_t                   count;
    logic                           full;
    logic                           push_ok;
    logic                           pop_ok;

    assign full    = (count == AUDIO_DEPTH);
    assign empty   = (count == 0);
    assign push_ok = push.valid && !full;
    assign pop_ok  = pop && !empty;

    // Head entry is shown without waiting for a pop
    assign data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // The link cannot stall, so a byte pushed into a full FIFO is lost
            if (push.valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/frame_buffer.sv */
`default_nettype none

module frame_buffer
    import media_pkg::*;
(
    input  wire        clk,
    input  fb_write_t  fb_wr,
    input  fb_index_t  rd_index,
    output logic [7:0] rd_data
);

    logic [7:0] mem [FB_DEPTH];

    always_ff @(posedge clk) begin
        if (fb_wr.en) begin
            mem[fb_wr.index] <= fb_wr.data;
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_index];
    end

endmodule

`default_nettype wire

/* hw/media_pkg.sv */
`default_nettype none

package media_pkg;

    // Address carried in the packet header
    typedef logic [23:0] pixel_addr_t;

    // Frame buffer geometry
    localparam int FB_DEPTH   = 4096;
    localparam int FB_INDEX_W = $clog2(FB_DEPTH);

    typedef logic [FB_INDEX_W-1:0] fb_index_t;

    // A byte strobe, used for both pixel and audio bytes
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } media_byte_t;

    typedef struct packed {
        logic       en;
        fb_index_t  index;
        logic [7:0] data;
    } fb_write_t;

    // Audio FIFO sizing
    localparam int AUDIO_DEPTH = 16;

    // One extra bit so a full FIFO can be told apart from an empty one
    typedef logic [$clog2(AUDIO_DEPTH):0] audio_count_t;

endpackage

`default_nettype wire

/* hw/media_rx_top.sv */
`default_nettype none

module media_rx_top
    import stream_pkg::*, media_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  rx_beat_t   rx,
    input  fb_index_t  fb_rd_index,
    output logic [7:0] fb_rd_data,
    input  logic       audio_pop,
    output logic [7:0] audio_data,
    output logic       audio_empty,
    output logic       audio_overflow
);

    logic        hdr_valid;
    pixel_addr_t hdr_addr;
    media_byte_t pixel;
    media_byte_t audio;
    fb_write_t   fb_wr;

    media_splitter splitter_i (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .hdr_valid (hdr_valid),
        .hdr_addr  (hdr_addr),
        .pixel     (pixel),
        .audio     (audio)
    );

    pixel_writer writer_i (
        .clk       (clk),
        .rst       (rst),
        .hdr_valid (hdr_valid),
        .hdr_addr  (hdr_addr),
        .pixel     (pixel),
        .fb_wr     (fb_wr)
    );

    frame_buffer buffer_i (
        .clk      (clk),
        .fb_wr    (fb_wr),
        .rd_index (fb_rd_index),
        .rd_data  (fb_rd_data)
    );

    audio_fifo fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (audio),
        .pop      (audio_pop),
        .data     (audio_data),
        .empty    (audio_empty),
        .overflow (audio_overflow)
    );

endmodule

`default_nettype wire

/* hw/media_splitter.sv */
`default_nettype none

module media_splitter
    import stream_pkg::*, media_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  rx_beat_t    rx,
    output logic        hdr_valid,
    output pixel_addr_t hdr_addr,
    output media_byte_t pixel,
    output media_byte_t audio
);

    split_state_t                        state;
    logic [$clog2(DIBITS_PER_BYTE)-1:0]  dibit_cnt;
    logic [$clog2(PIXEL_BYTES)-1:0]      byte_cnt;
    logic [7:0]                          byte_sr;
    logic [7:0]                          next_byte;
    logic                                byte_done;
    logic                                pixel_stb;
    logic                                audio_stb;
    logic [7:0]                          out_byte;

    // Bytes arrive most significant dibit first, so new dibits enter at the bottom
    assign next_byte = {byte_sr[5:0], rx.data};
    assign byte_done = rx.valid && (dibit_cnt == DIBITS_PER_BYTE - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= split_addr;
            dibit_cnt <= '0;
            byte_cnt  <= '0;
            hdr_valid <= 1'b0;
            pixel_stb <= 1'b0;
            audio_stb <= 1'b0;
        end else begin
            hdr_valid <= 1'b0;
            pixel_stb <= 1'b0;
            audio_stb <= 1'b0;

            if (!rx.valid) begin
                // End of packet, any partial byte is dropped here
                dibit_cnt <= '0;
                byte_cnt  <= '0;
                state     <= split_addr;
            end else begin
                dibit_cnt <= dibit_cnt + 1'b1;

                if (byte_done) begin
                    case (state)
                        split_addr: begin
                            if (byte_cnt == ADDR_BYTES - 1) begin
                                hdr_valid <= 1'b1;
                                byte_cnt  <= '0;
                                state     <= split_pixels;
                            end else begin
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                        end
                        split_pixels: begin
                            pixel_stb <= 1'b1;
                            if (byte_cnt == PIXEL_BYTES - 1) begin
                                byte_cnt <= '0;
                                state    <= split_audio;
                            end else begin
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                        end
                        split_audio: begin
                            // Audio runs until valid drops
                            audio_stb <= 1'b1;
                        end
                        default: begin
                            state <= split_addr;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx.valid) begin
            byte_sr <= next_byte;
        end
        if (byte_done) begin
            out_byte <= next_byte;
        end
        // Three header bytes shift through, leaving the full address after the last one
        if (byte_done && state == split_addr) begin
            hdr_addr <= {hdr_addr[15:0], next_byte};
        end
    end

    assign pixel = '{valid: pixel_stb, data: out_byte};
    assign audio = '{valid: audio_stb, data: out_byte};

endmodule

`default_nettype wire

/* hw/pixel_writer.sv */
`default_nettype none

module pixel_writer
    import media_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  logic        hdr_valid,
    input  pixel_addr_t hdr_addr,
    input  media_byte_t pixel,
    output fb_write_t   fb_wr
);

    fb_index_t base;
    fb_index_t ordinal;

    always_ff @(posedge clk) begin
        // The sum truncates to the index width, so writes wrap around the buffer
        fb_wr.index <= base + ordinal;
        fb_wr.data  <= pixel.data;

        if (hdr_valid) begin
            base <= hdr_addr[FB_INDEX_W-1:0];
        end

        if (rst) begin
            fb_wr.en <= 1'b0;
            ordinal  <= '0;
        end else begin
            fb_wr.en <= pixel.valid;
            if (hdr_valid) begin
                ordinal <= '0;
            end else if (pixel.valid) begin
                ordinal <= ordinal + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/stream_pkg.sv */
`default_nettype none

package stream_pkg;

    // One link symbol, two bits wide
    typedef logic [1:0] dibit_t;

    typedef struct packed {
        logic   valid;
        dibit_t data;
    } rx_beat_t;

    // Packet layout on the link
    localparam int DIBITS_PER_BYTE = 4;
    localparam int ADDR_BYTES      = 3;
    localparam int PIXEL_BYTES     = 80;

    // Field currently being received by the splitter
    typedef enum logic [1:0] {
        split_addr,
        split_pixels,
        split_audio
    } split_state_t;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module media_rx_tb -o media_rx_sim

# The log decides the result, so the simulator status is not allowed to stop the script here
./obj_dir/media_rx_sim 2>&1 | tee sim.log || true

if grep -q "STATUS: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* verif/media_rx_tb.sv */
`default_nettype none

module media_rx_tb
    import stream_pkg::*, media_pkg::*;
();

    typedef struct packed {
        pixel_addr_t base;
        logic [6:0]  n_pixels;
        logic [4:0]  n_audio;
        logic [1:0]  tail_dibits;
        logic        overflow;
    } packet_t;

    localparam int NUM_PACKETS = 5;
    localparam int AUDIO_WAIT_LIMIT = 20;

    // Full packet, short packet with a partial byte, wrap near 4095, overwrite, overflow
    localparam packet_t PACKETS [NUM_PACKETS] = '{
        '{base: 24'h123456, n_pixels: 7'd80, n_audio: 5'd5, tail_dibits: 2'd0, overflow: 1'b0},
        '{base: 24'h000100, n_pixels: 7'd37, n_audio: 5'd0, tail_dibits: 2'd3, overflow: 1'b0},
        '{base: 24'habcffa, n_pixels: 7'd80, n_audio: 5'd0, tail_dibits: 2'd0, overflow: 1'b0},
        '{base: 24'h550020, n_pixels: 7'd30, n_audio: 5'd0, tail_dibits: 2'd0, overflow: 1'b0},
        '{base: 24'h000800, n_pixels: 7'd80, n_audio: 5'd20, tail_dibits: 2'd0, overflow: 1'b1}
    };

    logic       clk;
    logic       rst;
    rx_beat_t   rx;
    fb_index_t  fb_rd_index;
    logic [7:0] fb_rd_data;
    logic       audio_pop;
    logic [7:0] audio_data;
    logic       audio_empty;
    logic       audio_overflow;

    logic [31:0] lfsr_state;
    logic [7:0]  ref_fb [FB_DEPTH];
    bit          written [FB_DEPTH];
    fb_write_t   exp_wr_q [$];
    logic [7:0]  exp_audio_q [$];
    fb_write_t   seen_wr;

    media_rx_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx),
        .fb_rd_index    (fb_rd_index),
        .fb_rd_data     (fb_rd_data),
        .audio_pop      (audio_pop),
        .audio_data     (audio_data),
        .audio_empty    (audio_empty),
        .audio_overflow (audio_overflow)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at time %0t: %s got 8'h%02h, expected 8'h%02h",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at time %0t: %s got %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_index(input string name, input fb_index_t got, input fb_index_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at time %0t: %s got 12'h%03h, expected 12'h%03h",
                               $time, name, got, exp));
        end
    endtask

    task automatic send_dibit(input dibit_t d);
        @(posedge clk);
        rx <= '{valid: 1'b1, data: d};
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int i = DIBITS_PER_BYTE - 1; i >= 0; i--) begin
            send_dibit(b[2*i +: 2]);
        end
    endtask

    task automatic send_packet(input packet_t pkt);
        logic [7:0] b;
        fb_write_t  wr;
        for (int i = ADDR_BYTES - 1; i >= 0; i--) begin
            send_byte(pkt.base[8*i +: 8]);
        end
        for (int p = 0; p < int'(pkt.n_pixels); p++) begin
            random_byte(b);
            wr.en = 1'b1;
            wr.index = pkt.base[FB_INDEX_W-1:0] + fb_index_t'(p);
            wr.data = b;
            ref_fb[wr.index] = b;
            written[wr.index] = 1'b1;
            exp_wr_q.push_back(wr);
            send_byte(b);
        end
        for (int a = 0; a < int'(pkt.n_audio); a++) begin
            random_byte(b);
            // Bytes beyond the FIFO depth are dropped by the DUT
            if (exp_audio_q.size() < AUDIO_DEPTH) begin
                exp_audio_q.push_back(b);
            end
            send_byte(b);
        end
        for (int t = 0; t < int'(pkt.tail_dibits); t++) begin
            send_dibit(2'b11);
        end
        @(posedge clk);
        rx <= '{valid: 1'b0, data: 2'b00};
        repeat (2) @(posedge clk);
    endtask

    task automatic check_fb(input fb_index_t idx);
        @(posedge clk);
        fb_rd_index <= idx;
        @(posedge clk);
        @(negedge clk);
        compare_byte("fb_rd_data", fb_rd_data, ref_fb[idx]);
    endtask

    task automatic wait_audio_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (audio_empty) begin
            cycles++;
            if (cycles >= AUDIO_WAIT_LIMIT) begin
                fail_run("Timed out after 20 cycles waiting for audio_empty to drop");
            end
            @(negedge clk);
        end
    endtask

    task automatic pop_audio();
        @(posedge clk);
        audio_pop <= 1'b1;
        @(posedge clk);
        audio_pop <= 1'b0;
    endtask

    task automatic check_packet(input packet_t pkt);
        logic [7:0] exp;
        @(negedge clk);
        compare_flag("audio_overflow", audio_overflow, pkt.overflow);
        if (exp_wr_q.size() != 0) begin
            fail_run("Some pixel bytes never reached the frame buffer");
        end
        for (int i = 0; i < FB_DEPTH; i++) begin
            if (written[i]) begin
                check_fb(fb_index_t'(i));
            end
        end
        while (exp_audio_q.size() > 0) begin
            exp = exp_audio_q.pop_front();
            wait_audio_ready();
            compare_byte("audio_data", audio_data, exp);
            pop_audio();
        end
        @(negedge clk);
        compare_flag("audio_empty", audio_empty, 1'b1);
    endtask

    // Every frame buffer write must match the next pixel sent, in order
    always @(negedge clk) begin
        if (!rst && dut_i.fb_wr.en === 1'b1) begin
            if (exp_wr_q.size() == 0) begin
                fail_run("Frame buffer was written with no pixel byte pending");
            end else begin
                seen_wr = exp_wr_q.pop_front();
                compare_index("fb_wr.index", dut_i.fb_wr.index, seen_wr.index);
                compare_byte("fb_wr.data", dut_i.fb_wr.data, seen_wr.data);
            end
        end
    end

    initial begin
        lfsr_state = 32'ha715;
        rst = 1'b1;
        rx = '{valid: 1'b0, data: 2'b00};
        fb_rd_index = '0;
        audio_pop = 1'b0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_flag("audio_empty", audio_empty, 1'b1);
        compare_flag("audio_overflow", audio_overflow, 1'b0);

        for (int n = 0; n < NUM_PACKETS; n++) begin
            send_packet(PACKETS[n]);
            check_packet(PACKETS[n]);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
